/* common/ifu_pkg.sv */
/*
 * Instruction fetch front end shared definitions
 * Address and instruction widths, PC and instruction word types
 * Request, response, flush, predecode and IR payload structs
 */
`default_nettype none

package ifu_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////
  localparam int PC_W    = 32;
  localparam int INSTR_W = 32;

  // Fetch address and raw instruction word
  typedef logic [PC_W-1:0]    pc_t;
  typedef logic [INSTR_W-1:0] instr_t;

  //////////////////////////////////////////////////
  // Channel payloads
  //////////////////////////////////////////////////

  // Fetch request towards memory
  typedef struct packed {
    pc_t  pc;
    // Sequential fetch, previous PC plus its length
    logic seq;
    // Length of the previous instruction was 32 bits
    logic seq_rv32;
  } fetch_req_t;

  // Fetch response from memory
  typedef struct packed {
    instr_t instr;
    // Bus error on this fetch
    logic   err;
  } fetch_rsp_t;

  // Flush target is op1 + op2
  typedef struct packed {
    pc_t op1;
    pc_t op2;
  } flush_ops_t;

  // Predecoder result for the returned instruction
  typedef struct packed {
    logic rv32;
    logic jal;
    logic bxx;
    // Sign-extended J or B offset
    pc_t  imm;
    logic prdt_taken;
  } predecode_t;

  // Instruction register contents handed to execute
  typedef struct packed {
    instr_t instr;
    pc_t    pc;
    logic   buserr;
    logic   prdt_taken;
  } ir_out_t;

endpackage

`default_nettype wire

/* fetch/fetch_ctrl.sv */
/*
 * Fetch control FSM
 * Reset, reset-request, outstanding, delayed-flush and halt-ack flags
 * Request valid, response ready, PC enable and IR load strobe
 */
`default_nettype none

module fetch_ctrl (
  input  logic clk,
  input  logic arst_n,
  input  logic req_ready,
  input  logic rsp_valid,
  input  logic flush_req,
  input  logic halt_req,
  input  logic ir_in_ready,
  output logic req_valid,
  output logic rsp_ready,
  output logic halt_ack,
  output logic reset_req,
  output logic flush_real,
  output logic dly_flush,
  output logic pc_ena,
  output logic load
);

  logic reset_flag;
  logic out_flag;
  logic req_hsk;
  logic rsp_hsk;
  logic fetch_gate;
  logic no_outs;

  assign req_hsk = req_valid & req_ready;
  assign rsp_hsk = rsp_valid & rsp_ready;

  //////////////////////////////////////////////////
  // Flag registers, set wins over clear
  //////////////////////////////////////////////////

  // Reset flag stays up for the first cycle only
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reset_flag <= 1'b1;
    end else begin
      reset_flag <= 1'b0;
    end
  end

  // Reset vector fetch pending until its request handshakes
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reset_req <= 1'b0;
    end else if (!reset_req && reset_flag) begin
      reset_req <= 1'b1;
    end else if (reset_req && req_hsk) begin
      reset_req <= 1'b0;
    end
  end

  // One request in flight at most
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_flag <= 1'b0;
    end else if (req_hsk) begin
      out_flag <= 1'b1;
    end else if (rsp_hsk) begin
      out_flag <= 1'b0;
    end
  end

  // Flush seen without a request handshake, issue it later
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dly_flush <= 1'b0;
    end else if (flush_req && !req_hsk) begin
      dly_flush <= 1'b1;
    end else if (dly_flush && req_hsk) begin
      dly_flush <= 1'b0;
    end
  end

  // Ack once the bus is quiet, drop a cycle after release
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      halt_ack <= 1'b0;
    end else if (halt_req && !halt_ack && no_outs) begin
      halt_ack <= 1'b1;
    end else if (halt_ack && !halt_req) begin
      halt_ack <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Channel control
  //////////////////////////////////////////////////

  // A response on the bus counts as finished for the halt
  assign no_outs    = ~out_flag | rsp_valid;
  assign flush_real = flush_req | dly_flush;

  // No fetching in the reset cycle or around a halt
  assign fetch_gate = ~reset_flag & ~halt_req & ~halt_ack;

  // New request only when the previous one is answered
  assign req_valid = fetch_gate & (~out_flag | rsp_hsk);

  // Flushed responses are drained and dropped
  // otherwise the next request must go out in the same cycle
  assign rsp_ready = flush_real | (ir_in_ready & req_ready & fetch_gate);

  assign pc_ena = req_hsk | flush_req;
  assign load   = rsp_hsk & ~flush_real;

endmodule

`default_nettype wire

/* fetch/pc_gen.sv */
/*
 * Fetch PC generator
 * Next-PC operand select and adder, PC register, new-PC-pending flag
 */
`default_nettype none

module pc_gen #(
  parameter ifu_pkg::pc_t RESET_VEC = 32'h0000_1000
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                reset_req,
  input  logic                flush_real,
  input  logic                dly_flush,
  input  logic                flush_req,
  input  logic                pc_ena,
  input  ifu_pkg::flush_ops_t flush,
  input  ifu_pkg::predecode_t pd,
  input  logic                ir_pc_load,
  output ifu_pkg::fetch_req_t req,
  output ifu_pkg::pc_t        pc,
  output logic                pc_newpend
);
  import ifu_pkg::*;

  pc_t  pc_r;
  pc_t  add_op1;
  pc_t  add_op2;
  pc_t  pc_sum;
  pc_t  pc_nxt;
  logic bjp_req;

  // Predicted redirect; the reset fetch has no response behind it
  assign bjp_req = (pd.jal | pd.bxx) & pd.prdt_taken & ~reset_req;

  //////////////////////////////////////////////////
  // Next PC select
  //////////////////////////////////////////////////
  always_comb begin
    add_op1 = pc_r;
    add_op2 = pd.rv32 ? pc_t'(4) : pc_t'(2);
    if (flush_req) begin
      add_op1 = flush.op1;
      add_op2 = flush.op2;
    end else if (dly_flush) begin
      // Target already sits in the PC register
      add_op2 = '0;
    end else if (bjp_req) begin
      add_op2 = pd.imm;
    end else if (reset_req) begin
      add_op1 = RESET_VEC;
      add_op2 = '0;
    end
  end

  assign pc_sum = add_op1 + add_op2;
  // Halfword aligned always
  assign pc_nxt = {pc_sum[PC_W-1:1], 1'b0};

  assign req.pc       = pc_nxt;
  assign req.seq      = ~flush_real & ~reset_req & ~bjp_req;
  assign req.seq_rv32 = pd.rv32;

  //////////////////////////////////////////////////
  // PC register and pending flag
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_r <= RESET_VEC;
    end else if (pc_ena) begin
      pc_r <= pc_nxt;
    end
  end

  // Set on a new PC, cleared once the IR has taken it
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_newpend <= 1'b0;
    end else if (pc_ena) begin
      pc_newpend <= 1'b1;
    end else if (ir_pc_load) begin
      pc_newpend <= 1'b0;
    end
  end

  assign pc = pc_r;

endmodule

`default_nettype wire

/* decode/branch_predecode.sv */
/*
 * Branch predecoder for the returned instruction
 * Length check, JAL and conditional branch detect
 * J and B immediate extract, static taken prediction
 */
`default_nettype none

module branch_predecode (
  input  ifu_pkg::instr_t     instr,
  output ifu_pkg::predecode_t pd
);
  import ifu_pkg::*;

  localparam logic [6:0] OPC_JAL = 7'b110_1111;
  localparam logic [6:0] OPC_BXX = 7'b110_0011;

  logic       rv32;
  logic       is_jal;
  logic       is_bxx;
  logic [6:0] opcode;
  pc_t        jal_imm;
  pc_t        bxx_imm;

  //////////////////////////////////////////////////
  // Length and type
  //////////////////////////////////////////////////

  // Low bits 11 mark a 32-bit encoding
  assign rv32   = (instr[1:0] == 2'b11);
  assign opcode = instr[6:0];

  // Compressed jumps are not predicted
  assign is_jal = rv32 & (opcode == OPC_JAL);
  assign is_bxx = rv32 & (opcode == OPC_BXX);

  //////////////////////////////////////////////////
  // Immediates
  //////////////////////////////////////////////////

  // J format, imm[20|10:1|11|19:12]
  assign jal_imm = {
    {(PC_W-20){instr[INSTR_W-1]}},
    instr[19:12],
    instr[20],
    instr[30:21],
    1'b0
  };

  // B format, imm[12|10:5] and imm[4:1|11]
  assign bxx_imm = {
    {(PC_W-12){instr[INSTR_W-1]}},
    instr[7],
    instr[30:25],
    instr[11:8],
    1'b0
  };

  //////////////////////////////////////////////////
  // Result
  //////////////////////////////////////////////////
  always_comb begin
    pd.rv32 = rv32;
    pd.jal  = is_jal;
    pd.bxx  = is_bxx;
    if (is_jal) begin
      pd.imm = jal_imm;
    end else if (is_bxx) begin
      pd.imm = bxx_imm;
    end else begin
      pd.imm = '0;
    end
    // Jumps always taken, backward branches taken
    pd.prdt_taken = is_jal | (is_bxx & bxx_imm[PC_W-1]);
  end

endmodule

`default_nettype wire

/* source/ir_stage.sv */
/*
 * Instruction register stage
 * Valid flag, execute handshake, payload and PC capture
 */
`default_nettype none

module ir_stage (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                load,
  input  logic                pc_newpend,
  input  logic                flush_real,
  input  ifu_pkg::fetch_rsp_t rsp,
  input  logic                pd_taken,
  input  ifu_pkg::pc_t        pc,
  input  logic                ir_ready,
  output logic                ir_valid,
  output ifu_pkg::ir_out_t    ir,
  output logic                ir_in_ready,
  output logic                ir_pc_load
);

  logic ir_valid_clr;

  // Drained by execute or dropped by a flush
  assign ir_valid_clr = (ir_valid & ir_ready) | (ir_valid & flush_real);

  // Empty or being emptied this cycle
  assign ir_in_ready = ~ir_valid | ir_valid_clr;

  // PC of the outstanding fetch goes in as soon as there is room
  assign ir_pc_load = pc_newpend & ir_in_ready & ~flush_real;

  //////////////////////////////////////////////////
  // Valid flag, load wins
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ir_valid <= 1'b0;
    end else if (load) begin
      ir_valid <= 1'b1;
    end else if (ir_valid_clr) begin
      ir_valid <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Payload
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (load) begin
      ir.instr      <= rsp.instr;
      ir.buserr     <= rsp.err;
      ir.prdt_taken <= pd_taken;
    end
    // PC loads on its own strobe, ahead of or with the instruction
    if (ir_pc_load) begin
      ir.pc <= pc;
    end
  end

endmodule

`default_nettype wire

/* source/ifu_top.sv */
/*
 * Instruction fetch unit top level
 * Connects fetch control, PC generator, predecoder and IR stage
 */
`default_nettype none

module ifu_top #(
  parameter ifu_pkg::pc_t RESET_VEC = 32'h0000_1000
) (
  input  logic                 clk,
  input  logic                 arst_n,
  // Request channel to memory
  output logic                 req_valid,
  output ifu_pkg::fetch_req_t  req,
  input  logic                 req_ready,
  // Response channel from memory
  input  logic                 rsp_valid,
  input  ifu_pkg::fetch_rsp_t  rsp,
  output logic                 rsp_ready,
  // IR channel to execute
  output logic                 ir_valid,
  output ifu_pkg::ir_out_t     ir,
  input  logic                 ir_ready,
  // Pipeline flush, always accepted
  input  logic                 flush_req,
  input  ifu_pkg::flush_ops_t  flush,
  // Halt handshake
  input  logic                 halt_req,
  output logic                 halt_ack
);
  import ifu_pkg::*;

  // Control to PC generator
  logic       reset_req;
  logic       flush_real;
  logic       dly_flush;
  logic       pc_ena;
  // Control and PC generator to IR stage
  logic       load;
  logic       ir_in_ready;
  logic       ir_pc_load;
  logic       pc_newpend;
  pc_t        pc;
  predecode_t pd;

  fetch_ctrl u_fetch_ctrl (
    .clk         (clk),
    .arst_n      (arst_n),
    .req_ready   (req_ready),
    .rsp_valid   (rsp_valid),
    .flush_req   (flush_req),
    .halt_req    (halt_req),
    .ir_in_ready (ir_in_ready),
    .req_valid   (req_valid),
    .rsp_ready   (rsp_ready),
    .halt_ack    (halt_ack),
    .reset_req   (reset_req),
    .flush_real  (flush_real),
    .dly_flush   (dly_flush),
    .pc_ena      (pc_ena),
    .load        (load)
  );

  pc_gen #(.RESET_VEC(RESET_VEC)) u_pc_gen (
    .clk        (clk),
    .arst_n     (arst_n),
    .reset_req  (reset_req),
    .flush_real (flush_real),
    .dly_flush  (dly_flush),
    .flush_req  (flush_req),
    .pc_ena     (pc_ena),
    .flush      (flush),
    .pd         (pd),
    .ir_pc_load (ir_pc_load),
    .req        (req),
    .pc         (pc),
    .pc_newpend (pc_newpend)
  );

  branch_predecode u_branch_predecode (
    .instr (rsp.instr),
    .pd    (pd)
  );

  ir_stage u_ir_stage (
    .clk         (clk),
    .arst_n      (arst_n),
    .load        (load),
    .pc_newpend  (pc_newpend),
    .flush_real  (flush_real),
    .rsp         (rsp),
    .pd_taken    (pd.prdt_taken),
    .pc          (pc),
    .ir_ready    (ir_ready),
    .ir_valid    (ir_valid),
    .ir          (ir),
    .ir_in_ready (ir_in_ready),
    .ir_pc_load  (ir_pc_load)
  );

endmodule

`default_nettype wire

/* verif/ifu_properties.sv */
/*
 * Protocol assertions for the fetch unit, bound to ifu_top
 * Request hold, IR hold, PC alignment and halt rules
 */
`default_nettype none

module ifu_properties (
  input logic                clk,
  input logic                arst_n,
  input logic                req_valid,
  input ifu_pkg::fetch_req_t req,
  input logic                req_ready,
  input logic                ir_valid,
  input ifu_pkg::ir_out_t    ir,
  input logic                ir_ready,
  input logic                flush_req,
  input logic                halt_req,
  input logic                halt_ack
);
  timeunit 1ns;
  timeprecision 1ps;
  import ifu_pkg::*;

  // Request valid is always driven
  req_valid_known: assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown(req_valid))
    else $error("req_valid is unknown");

  // Stalled request keeps its address unless a flush or halt steps in
  req_hold: assert property (@(posedge clk) disable iff (!arst_n)
    ($past(req_valid && !req_ready) && !halt_req && !flush_req)
      |-> (req_valid && req.pc == $past(req.pc) && req.seq == $past(req.seq)))
    else $error("request changed while req_ready was low");

  // IR holds under back-pressure, a flush empties it instead
  ir_hold: assert property (@(posedge clk) disable iff (!arst_n)
    ($past(ir_valid && !ir_ready) && !$past(flush_req)) |-> (ir_valid && ir == $past(ir)))
    else $error("IR changed while ir_ready was low");

  pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
    req_valid |-> !req.pc[0])
    else $error("request PC bit 0 is set");

  halt_quiet: assert property (@(posedge clk) disable iff (!arst_n)
    halt_ack |-> !req_valid)
    else $error("request raised while halt_ack is high");

endmodule

`default_nettype wire

/* verif/ifu_tb.sv */
/*
 * Fetch unit testbench
 * Clock, reset, random stimulus, memory responder, reference model
 */
`default_nettype none

module ifu_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import ifu_pkg::*;

  localparam int   CLK_PERIOD   = 40;
  localparam int   DRIVE_DLY    = 2;
  localparam int   RESET_CYCLES = 8;
  localparam int   STALL_LIMIT  = 100;
  localparam int   HALT_LIMIT   = 50;
  localparam pc_t  RESET_VEC    = 32'h0000_1000;

  logic clk, arst_n, req_valid, req_ready, rsp_valid, rsp_ready;
  logic ir_valid, ir_ready, flush_req, halt_req, halt_ack;
  fetch_req_t req;
  fetch_rsp_t rsp;
  ir_out_t    ir;
  flush_ops_t flush;

  // Reference model and monitor state
  pc_t     exp_pc, out_pc, mon_req_pc, rsp_addr;
  logic    exp_seq, exp_rv32, owed, out_stale, mon_req_hs, mon_rsp_hs;
  logic    ack_prev, halt_req_prev, owed_prev, rspv_prev, rsp_pend, aborted, branch_mode;
  ir_out_t ir_q[$];
  int checks, errors, n_tests, n_failed, n_req, n_ir, n_seq, n_taken, n_fallthru;
  int n_flush, n_halt, rsp_wait, since_req, halt_wait, halt_hold, n_ir_stall;
  int p_req_ready, p_ir_ready, p_flush, p_halt;

  ifu_top #(.RESET_VEC(RESET_VEC)) dut_i (
    .clk(clk), .arst_n(arst_n),
    .req_valid(req_valid), .req(req), .req_ready(req_ready),
    .rsp_valid(rsp_valid), .rsp(rsp), .rsp_ready(rsp_ready),
    .ir_valid(ir_valid), .ir(ir), .ir_ready(ir_ready),
    .flush_req(flush_req), .flush(flush),
    .halt_req(halt_req), .halt_ack(halt_ack)
  );

  bind ifu_top ifu_properties props_i (
    .clk(clk), .arst_n(arst_n), .req_valid(req_valid), .req(req), .req_ready(req_ready),
    .ir_valid(ir_valid), .ir(ir), .ir_ready(ir_ready), .flush_req(flush_req),
    .halt_req(halt_req), .halt_ack(halt_ack)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Memory image and RISC-V offset decode
  //////////////////////////////////////////////////

  // Hashed address picks 16-bit, plain 32-bit, JAL or branch
  function automatic instr_t mem_word(pc_t addr);
    logic [31:0] h;
    h = (addr ^ 32'h5bd1_e995) * 32'h9e37_79b1;
    h = h ^ (h >> 13);
    case (h[2:0])
      3'd0, 3'd1, 3'd2: return {h[31:2], h[6] ? 2'b01 : 2'b10};
      3'd3, 3'd4: return {h[31:7], 7'b001_0011};
      3'd5: return branch_mode ? {h[31:7], 7'b110_1111} : {h[31:7], 7'b011_0011};
      default: return branch_mode ? {h[31:7], 7'b110_0011} : {h[31:7], 7'b001_0011};
    endcase
  endfunction

  // J type offset with the sign in bit 31
  function automatic pc_t jal_offset(instr_t w);
    pc_t off;
    off = w[31] ? '1 : '0;
    off[19:12] = w[19:12];
    off[11] = w[20];
    off[10:1] = w[30:21];
    off[0] = 1'b0;
    return off;
  endfunction

  // B type offset
  function automatic pc_t branch_offset(instr_t w);
    pc_t off;
    off = w[31] ? '1 : '0;
    off[11] = w[7];
    off[10:5] = w[30:25];
    off[4:1] = w[11:8];
    off[0] = 1'b0;
    return off;
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////
  task automatic report_error(string msg);
    errors++;
    $display("Error at %0d ns: %s", $time, msg);
  endtask

  task automatic check_req(fetch_req_t got, fetch_req_t exp, logic check_len);
    checks++;
    if (got.pc !== exp.pc || got.seq !== exp.seq ||
        (check_len && got.seq_rv32 !== exp.seq_rv32)) begin
      report_error($sformatf("request pc %h seq %b len32 %b, expected pc %h seq %b len32 %b",
        got.pc, got.seq, got.seq_rv32, exp.pc, exp.seq, exp.seq_rv32));
    end
  endtask

  task automatic check_ir(ir_out_t got, ir_out_t exp);
    checks++;
    if (got !== exp) begin
      report_error($sformatf("IR %h pc %h err %b taken %b, expected %h pc %h err %b taken %b",
        got.instr, got.pc, got.buserr, got.prdt_taken,
        exp.instr, exp.pc, exp.buserr, exp.prdt_taken));
    end
  endtask

  //////////////////////////////////////////////////
  // Monitor and reference model
  //////////////////////////////////////////////////

  // Sampled mid-cycle while values hold until the next rising edge
  task automatic sample_cycle();
    fetch_req_t exp_req;
    ir_out_t    exp_ir;
    logic       rv32, is_jal, is_bxx, taken;
    mon_req_hs = req_valid & req_ready;
    mon_rsp_hs = rsp_valid & rsp_ready;
    mon_req_pc = req.pc;
    // Halt rules
    if ((halt_req || halt_ack) && req_valid) report_error("request raised while halting");
    if (halt_ack && !ack_prev && owed_prev && !rspv_prev)
      report_error("halt_ack rose with a response still owed");
    if (halt_ack && ack_prev && !halt_req_prev) report_error("halt_ack held after release");
    if (halt_ack && !ack_prev) n_halt++;
    ack_prev = halt_ack;
    halt_req_prev = halt_req;
    owed_prev = owed;
    rspv_prev = rsp_valid;
    // Response ready drains a flush and otherwise waits for both consumers
    if (flush_req && !rsp_ready) report_error("rsp_ready low during a flush");
    if (rsp_ready && !flush_req && !out_stale && (!req_ready || (ir_valid && !ir_ready)))
      report_error("rsp_ready high under back-pressure");
    // IR contents against the model and popped on drain or flush
    if (ir_valid && ir_q.size() == 0) begin
      report_error("IR valid with no expected entry");
    end else if (ir_valid) begin
      check_ir(ir, ir_q[0]);
      if (ir_ready) begin
        void'(ir_q.pop_front());
        n_ir++;
      end else if (flush_req) begin
        void'(ir_q.pop_front());
      end else begin
        n_ir_stall++;
      end
    end else if (ir_q.size() != 0) begin
      report_error("expected IR entry never became valid");
      ir_q.delete();
    end
    if (mon_rsp_hs) owed = 1'b0;
    // Flush beats any response of this cycle
    if (flush_req) begin
      exp_pc = (flush.op1 + flush.op2) & ~pc_t'(1);
      exp_seq = 1'b0;
      out_stale = 1'b1;
      n_flush++;
    end else if (mon_rsp_hs && !out_stale) begin
      rv32 = (rsp.instr[1:0] == 2'b11);
      is_jal = rv32 && (rsp.instr[6:0] == 7'b110_1111);
      is_bxx = rv32 && (rsp.instr[6:0] == 7'b110_0011);
      taken = is_jal || (is_bxx && branch_offset(rsp.instr) >= 32'h8000_0000);
      if (taken) begin
        exp_pc = (out_pc + (is_jal ? jal_offset(rsp.instr) : branch_offset(rsp.instr)))
                 & ~pc_t'(1);
        exp_seq = 1'b0;
        n_taken++;
      end else begin
        exp_pc = out_pc + (rv32 ? 32'd4 : 32'd2);
        exp_seq = 1'b1;
        exp_rv32 = rv32;
        n_seq++;
        if (is_bxx) n_fallthru++;
      end
      exp_ir = '{instr: rsp.instr, pc: out_pc, buserr: rsp.err, prdt_taken: taken};
      ir_q.push_back(exp_ir);
    end
    if (mon_req_hs) begin
      exp_req = '{pc: exp_pc, seq: exp_seq, seq_rv32: exp_rv32};
      check_req(req, exp_req, exp_seq);
      out_pc = exp_pc;
      owed = 1'b1;
      out_stale = 1'b0;
      n_req++;
    end
  endtask

  always @(negedge clk) begin
    if (arst_n) sample_cycle();
  end

  //////////////////////////////////////////////////
  // Stimulus and memory responder
  //////////////////////////////////////////////////
  task automatic drive_cycle();
    if (mon_rsp_hs) begin
      rsp_pend = 1'b0;
      rsp_valid = 1'b0;
      rsp = '0;
    end
    if (mon_req_hs) begin
      rsp_pend = 1'b1;
      rsp_addr = mon_req_pc;
      rsp_wait = $urandom_range(0, 3);
    end
    if (rsp_pend && !rsp_valid) begin
      if (rsp_wait == 0) begin
        rsp_valid = 1'b1;
        rsp.instr = mem_word(rsp_addr);
        rsp.err = ($urandom_range(0, 15) == 0);
      end else begin
        rsp_wait--;
      end
    end
    req_ready = ($urandom_range(0, 99) < p_req_ready);
    ir_ready = ($urandom_range(0, 99) < p_ir_ready);
    flush_req = ($urandom_range(0, 99) < p_flush);
    flush.op1 = $urandom();
    flush.op2 = $urandom_range(0, 255);
    // Halt episode released a few cycles after the ack
    if (halt_req) begin
      halt_wait++;
      if (halt_ack) halt_hold--;
      if (halt_ack && halt_hold <= 0) halt_req = 1'b0;
      if (!halt_ack && halt_wait > HALT_LIMIT && !aborted) begin
        aborted = 1'b1;
        errors++;
        $display("Timeout: halt_ack never rose within %0d cycles", HALT_LIMIT);
      end
    end else if (!halt_ack && $urandom_range(0, 99) < p_halt) begin
      halt_req = 1'b1;
      halt_wait = 0;
      halt_hold = $urandom_range(1, 4);
    end
    // Fetch must keep moving outside a halt
    if (mon_req_hs) since_req = 0;
    else if (!halt_req && !halt_ack) since_req++;
    if (since_req > STALL_LIMIT && !aborted) begin
      aborted = 1'b1;
      errors++;
      $display("Timeout: no request accepted for %0d cycles", STALL_LIMIT);
    end
  endtask

  task automatic run_phase(int cycles);
    int i;
    i = 0;
    while (i < cycles && !aborted) begin
      @(posedge clk);
      #DRIVE_DLY;
      drive_cycle();
      i++;
    end
  endtask

  task automatic finish_phase(string name, int err0, logic seen);
    if (!seen && !aborted) begin
      errors++;
      $display("Phase %s ended without exercising its feature", name);
    end
    n_tests++;
    if (errors != err0) n_failed++;
    $display("Test %-18s %s, %0d errors", name, (errors == err0) ? "ok" : "FAILED",
      errors - err0);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    int err0;
    int i;
    int stall0;
    void'($urandom(32'hd179));
    arst_n = 1'b0;
    {req_ready, rsp_valid, ir_ready, flush_req, halt_req} = '0;
    rsp = '0;
    flush = '0;
    exp_pc = RESET_VEC;
    {exp_seq, exp_rv32, owed, out_stale, mon_req_hs, mon_rsp_hs} = '0;
    {ack_prev, halt_req_prev, owed_prev, rspv_prev, rsp_pend, aborted, branch_mode} = '0;
    {checks, errors, n_tests, n_failed, n_req, n_ir, n_seq, n_taken, n_fallthru} = '0;
    {n_flush, n_halt, rsp_wait, since_req, halt_wait, halt_hold, n_ir_stall} = '0;
    p_req_ready = 100;
    p_ir_ready = 100;
    p_flush = 0;
    p_halt = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    if (req_valid || rsp_ready || ir_valid || halt_ack)
      report_error("control outputs active during reset");
    #DRIVE_DLY;
    arst_n = 1'b1;

    // First request carries the reset vector
    err0 = errors;
    i = 0;
    while (n_req == 0 && !aborted) begin
      run_phase(1);
      i++;
      if (i > 20) begin
        aborted = 1'b1;
        errors++;
        $display("Timeout: no request after reset");
      end
    end
    finish_phase("reset_vector", err0, n_req > 0);

    err0 = errors;
    p_req_ready = 80;
    p_ir_ready = 90;
    run_phase(300);
    finish_phase("sequential_fetch", err0, n_seq > 0);

    err0 = errors;
    branch_mode = 1'b1;
    run_phase(400);
    finish_phase("branch_prediction", err0, n_taken > 0 && n_fallthru > 0);

    err0 = errors;
    p_flush = 6;
    run_phase(400);
    finish_phase("flush", err0, n_flush > 0);

    err0 = errors;
    p_flush = 2;
    p_halt = 3;
    run_phase(400);
    finish_phase("halt", err0, n_halt > 0);

    err0 = errors;
    stall0 = n_ir_stall;
    p_req_ready = 50;
    p_ir_ready = 30;
    run_phase(500);
    finish_phase("ir_backpressure", err0, n_ir_stall > stall0);

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
      n_tests, n_failed, checks, errors);
    if (aborted || errors != 0) begin
      $display("Test failures found");
    end else begin
      $display("All tests passed!");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
common/ifu_pkg.sv
fetch/fetch_ctrl.sv
fetch/pc_gen.sv
decode/branch_predecode.sv
source/ir_stage.sv
source/ifu_top.sv
verif/ifu_properties.sv
verif/ifu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the fetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module ifu_tb -f tb.f -o ifu_sim > build.log 2>&1 \
  && ./obj_dir/ifu_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "All tests passed!" sim.log \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL"; exit 1; }
